// ==== verilog/csr_pkg.sv ====
// shared types and constants of the machine-mode csr block

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int N_PERF_CNT = 8;
  localparam int CNT_IDX_W  = $clog2(N_PERF_CNT);  // bits that pick one counter

  ////////////////////////////////////////////////////////////
  // register numbers
  ////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    MSTATUS  = 12'h300,
    MISA     = 12'h301,
    MTVEC    = 12'h305,
    MEPC     = 12'h341,
    MCAUSE   = 12'h342,
    PCCR_ALL = 12'h79F,  // write hits every counter
    PCER     = 12'h7A0,  // event enable mask
    PCMR     = 12'h7A1   // mode, enable and saturate
  } csr_num_e;

  // counters live at 0x780..0x79f
  localparam logic [6:0] PCCR_PAGE = 7'h3C;

  typedef struct packed {
    logic [6:0] page;
    logic [4:0] index;
  } csr_ctr_addr_t;

  // one register number, seen either by name or as page plus counter index
  typedef union packed {
    csr_num_e      num;
    csr_ctr_addr_t ctr;
  } csr_addr_u;

  typedef enum logic [1:0] {
    NONE  = 2'd0,
    WRITE = 2'd1,
    SET   = 2'd2,
    CLEAR = 2'd3
  } csr_op_e;

  typedef struct packed {
    logic       irq;   // interrupt flag, lands in bit 31 on read
    logic [4:0] code;
  } exc_cause_t;

  ////////////////////////////////////////////////////////////
  // fixed register contents and bit positions
  ////////////////////////////////////////////////////////////

  localparam logic [XLEN-1:0] MISA_VALUE =
      (XLEN'(1) << 2)     // c extension
    | (XLEN'(1) << 8)     // i base isa
    | (XLEN'(1) << 12)    // m extension
    | (XLEN'(1) << 30);   // mxl = 1, rv32

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam logic [1:0] PRIV_LVL_M = 2'b11;

  localparam int PCMR_EN_BIT  = 0;
  localparam int PCMR_SAT_BIT = 1;
  localparam logic [1:0] PCMR_RESET = 2'b11;  // enabled and saturating

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic instr_valid;
    logic imiss;
    logic pc_set;        // only masks imiss
    logic load;
    logic store;
    logic jump;
    logic branch;
    logic branch_taken;
  } perf_events_t;

  typedef struct packed {
    logic            save_cause;
    logic            save_if;
    logic            save_id;
    logic            restore_mret;
    exc_cause_t      cause;
    logic [XLEN-1:0] pc_if;
    logic [XLEN-1:0] pc_id;
  } trap_ctrl_t;

  typedef struct packed {
    logic            access;
    csr_addr_u       addr;
    csr_op_e         op;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

endpackage

// ==== verilog/csr_access.sv ====
// csr address decode, read mux and write value from the access operation

`timescale 1ns/1ps

module csr_access (
  input  csr_pkg::csr_req_t                   req_i,
  input  logic [csr_pkg::XLEN-1:0]            boot_addr_i,
  input  logic [csr_pkg::XLEN-1:0]            mstatus_i,
  input  logic [csr_pkg::XLEN-1:0]            mepc_i,
  input  csr_pkg::exc_cause_t                 mcause_i,
  input  logic [csr_pkg::XLEN-1:0]            cnt_rdata_i,
  input  logic [csr_pkg::N_PERF_CNT-1:0]      pcer_i,
  input  logic [1:0]                          pcmr_i,
  output logic [csr_pkg::XLEN-1:0]            rdata_o,
  output logic [csr_pkg::XLEN-1:0]            wr_data_o,
  output logic                                wr_mstatus_o,
  output logic                                wr_mepc_o,
  output logic                                wr_mcause_o,
  output logic                                sel_pcer_o,
  output logic                                sel_pcmr_o,
  output logic                                cnt_we_o,
  output logic                                sel_all_o,
  output logic [4:0]                          sel_index_o
);

  logic we;          // access with a real operation
  logic hit_mstatus;
  logic hit_mepc;
  logic hit_mcause;
  logic hit_pcer;
  logic hit_pcmr;
  logic hit_all;
  logic hit_cnt;     // any counter address, all-select included

  ////////////////////////////////////////////////////////////
  // decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o     = '0;  // unknown addresses read zero
    hit_mstatus = 1'b0;
    hit_mepc    = 1'b0;
    hit_mcause  = 1'b0;
    hit_pcer    = 1'b0;
    hit_pcmr    = 1'b0;
    hit_all     = 1'b0;
    hit_cnt     = 1'b0;

    // by name first, then by counter page
    case (req_i.addr.num)
      csr_pkg::MSTATUS: begin
        hit_mstatus = 1'b1;
        rdata_o     = mstatus_i;
      end
      csr_pkg::MISA:  rdata_o = csr_pkg::MISA_VALUE;
      csr_pkg::MTVEC: rdata_o = boot_addr_i;  // traps go to the boot address
      csr_pkg::MEPC: begin
        hit_mepc = 1'b1;
        rdata_o  = mepc_i;
      end
      csr_pkg::MCAUSE: begin
        hit_mcause = 1'b1;
        rdata_o    = {mcause_i.irq, {(csr_pkg::XLEN-6){1'b0}}, mcause_i.code};
      end
      csr_pkg::PCER: begin
        hit_pcer                         = 1'b1;
        rdata_o[csr_pkg::N_PERF_CNT-1:0] = pcer_i;
      end
      csr_pkg::PCMR: begin
        hit_pcmr     = 1'b1;
        rdata_o[1:0] = pcmr_i;
      end
      csr_pkg::PCCR_ALL: begin
        hit_all = 1'b1;   // reads zero
        hit_cnt = 1'b1;
      end
      default: begin
        if (req_i.addr.ctr.page == csr_pkg::PCCR_PAGE) begin
          hit_cnt = 1'b1;
          rdata_o = cnt_rdata_i;  // zero past the last counter
        end
      end
    endcase
  end

  assign sel_index_o = req_i.addr.ctr.index;

  ////////////////////////////////////////////////////////////
  // operation result and write strobes
  ////////////////////////////////////////////////////////////

  assign we = req_i.access && (req_i.op != csr_pkg::NONE);

  always_comb begin
    unique case (req_i.op)
      csr_pkg::WRITE: wr_data_o = req_i.wdata;
      csr_pkg::SET:   wr_data_o = rdata_o | req_i.wdata;
      csr_pkg::CLEAR: wr_data_o = rdata_o & ~req_i.wdata;
      default:        wr_data_o = req_i.wdata;  // no strobe goes out
    endcase
  end

  assign wr_mstatus_o = we && hit_mstatus;
  assign wr_mepc_o    = we && hit_mepc;
  assign wr_mcause_o  = we && hit_mcause;
  assign sel_pcer_o   = we && hit_pcer;
  assign sel_pcmr_o   = we && hit_pcmr;
  assign cnt_we_o     = we && hit_cnt;
  assign sel_all_o    = hit_all;

endmodule

// ==== verilog/machine_csrs.sv ====
// machine trap registers: mstatus, mepc and mcause with trap entry and mret

`timescale 1ns/1ps

module machine_csrs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  csr_pkg::trap_ctrl_t          trap_i,
  input  logic [csr_pkg::XLEN-1:0]     wr_data_i,
  input  logic                         wr_mstatus_i,
  input  logic                         wr_mepc_i,
  input  logic                         wr_mcause_i,
  output logic [csr_pkg::XLEN-1:0]     mstatus_o,
  output logic [csr_pkg::XLEN-1:0]     mepc_o,
  output csr_pkg::exc_cause_t          mcause_o,
  output logic                         irq_enable_o
);

  // implemented mstatus bits, mpp is fixed to machine mode
  typedef struct packed {
    logic mie;
    logic mpie;
  } status_t;

  status_t                     status_q;
  status_t                     status_d;
  logic [csr_pkg::XLEN-1:0]    mepc_q;
  logic [csr_pkg::XLEN-1:0]    mepc_d;
  csr_pkg::exc_cause_t         mcause_q;
  csr_pkg::exc_cause_t         mcause_d;
  logic [csr_pkg::XLEN-1:0]    trap_pc;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  // fetch pc when the fault came from fetch, else decode pc
  assign trap_pc = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;

  always_comb begin
    status_d = status_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // software writes, lowest priority
    if (wr_mstatus_i) begin
      status_d.mie  = wr_data_i[csr_pkg::MSTATUS_MIE_BIT];
      status_d.mpie = wr_data_i[csr_pkg::MSTATUS_MPIE_BIT];
    end
    if (wr_mepc_i) begin
      mepc_d = wr_data_i;
    end
    if (wr_mcause_i) begin
      mcause_d.irq  = wr_data_i[csr_pkg::XLEN-1];
      mcause_d.code = wr_data_i[4:0];
    end

    if (trap_i.save_cause) begin
      mepc_d        = trap_pc;
      mcause_d      = trap_i.cause;
      status_d.mpie = status_q.mie;  // remember enable, then mask
      status_d.mie  = 1'b0;
    end else if (trap_i.restore_mret) begin
      status_d.mie  = status_q.mpie;
      status_d.mpie = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      status_q <= status_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  // read image of mstatus
  always_comb begin
    mstatus_o                                       = '0;
    mstatus_o[csr_pkg::MSTATUS_MIE_BIT]             = status_q.mie;
    mstatus_o[csr_pkg::MSTATUS_MPIE_BIT]            = status_q.mpie;
    mstatus_o[csr_pkg::MSTATUS_MPP_LSB +: 2]        = csr_pkg::PRIV_LVL_M;
  end

  assign mepc_o       = mepc_q;
  assign mcause_o     = mcause_q;
  assign irq_enable_o = status_q.mie;  // global machine interrupt enable

endmodule

// ==== verilog/perf_counters.sv ====
// performance counter array with event mask and mode register

`timescale 1ns/1ps

module perf_counters (
  input  logic                              clk,
  input  logic                              rst_n,
  input  csr_pkg::perf_events_t             events_i,
  input  logic [csr_pkg::XLEN-1:0]          wr_data_i,
  input  logic                              sel_pcer_i,
  input  logic                              sel_pcmr_i,
  input  logic                              cnt_we_i,
  input  logic                              sel_all_i,
  input  logic [4:0]                        sel_index_i,
  output logic [csr_pkg::XLEN-1:0]          cnt_rdata_o,
  output logic [csr_pkg::N_PERF_CNT-1:0]    pcer_o,
  output logic [1:0]                        pcmr_o
);

  logic [csr_pkg::N_PERF_CNT-1:0]                         cnt_in;     // raw event per counter
  logic [csr_pkg::N_PERF_CNT-1:0]                         cnt_inc;
  logic [csr_pkg::N_PERF_CNT-1:0]                         cnt_inc_q;  // one cycle late
  logic [csr_pkg::N_PERF_CNT-1:0][csr_pkg::XLEN-1:0]      cnt_q;
  logic [csr_pkg::N_PERF_CNT-1:0][csr_pkg::XLEN-1:0]      cnt_d;
  logic [csr_pkg::N_PERF_CNT-1:0]                         pcer_q;
  logic [1:0]                                             pcmr_q;

  ////////////////////////////////////////////////////////////
  // event to counter map
  ////////////////////////////////////////////////////////////

  assign cnt_in[0] = 1'b1;                                    // cycles
  assign cnt_in[1] = events_i.instr_valid;                    // instructions
  assign cnt_in[2] = events_i.imiss & ~events_i.pc_set;       // fetch stalls, no jumps
  assign cnt_in[3] = events_i.load;
  assign cnt_in[4] = events_i.store;
  assign cnt_in[5] = events_i.jump;
  assign cnt_in[6] = events_i.branch;
  assign cnt_in[7] = events_i.branch_taken;

  assign cnt_inc = cnt_in & pcer_q & {csr_pkg::N_PERF_CNT{pcmr_q[csr_pkg::PCMR_EN_BIT]}};

  ////////////////////////////////////////////////////////////
  // counter update
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < csr_pkg::N_PERF_CNT; c++) begin
      cnt_d[c] = cnt_q[c];

      // hold at all-ones when saturating
      if (cnt_inc_q[c] && !((&cnt_q[c]) && pcmr_q[csr_pkg::PCMR_SAT_BIT])) begin
        cnt_d[c] = cnt_q[c] + csr_pkg::XLEN'(1);
      end

      // software write wins over the increment
      if (cnt_we_i && (sel_all_i || (sel_index_i == 5'(c)))) begin
        cnt_d[c] = wr_data_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q    <= '0;
      pcmr_q    <= csr_pkg::PCMR_RESET;
      cnt_inc_q <= '0;
      cnt_q     <= '0;
    end else begin
      if (sel_pcer_i) begin
        pcer_q <= wr_data_i[csr_pkg::N_PERF_CNT-1:0];
      end
      if (sel_pcmr_i) begin
        pcmr_q <= wr_data_i[1:0];
      end
      cnt_inc_q <= cnt_inc;
      cnt_q     <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////

  // indices past the array read zero
  assign cnt_rdata_o = (sel_index_i < 5'(csr_pkg::N_PERF_CNT)) ?
                       cnt_q[sel_index_i[csr_pkg::CNT_IDX_W-1:0]] : '0;

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

endmodule

// ==== verilog/cs_registers.sv ====
// machine-mode csr block top: access decode, trap registers and counters

`timescale 1ns/1ps

module cs_registers (
  input  logic                         clk,
  input  logic                         rst_n,
  input  csr_pkg::csr_req_t            csr_req_i,
  input  csr_pkg::trap_ctrl_t          trap_i,
  input  csr_pkg::perf_events_t        events_i,
  input  logic [csr_pkg::XLEN-1:0]     boot_addr_i,
  output logic [csr_pkg::XLEN-1:0]     rdata_o,
  output logic                         irq_enable_o,
  output logic [csr_pkg::XLEN-1:0]     mepc_o
);

  // write side, from the access decoder
  logic [csr_pkg::XLEN-1:0]          wr_data;
  logic                              wr_mstatus;
  logic                              wr_mepc;
  logic                              wr_mcause;
  logic                              sel_pcer;
  logic                              sel_pcmr;
  logic                              sel_all;
  logic                              cnt_we;
  logic [4:0]                        sel_cnt;

  // read side, back into the decoder
  logic [csr_pkg::XLEN-1:0]          mstatus_rdata;
  csr_pkg::exc_cause_t               mcause;
  logic [csr_pkg::XLEN-1:0]          cnt_rdata;
  logic [csr_pkg::N_PERF_CNT-1:0]    pcer;
  logic [1:0]                        pcmr;

  csr_access i_csr_access (
    .req_i        (csr_req_i),
    .boot_addr_i  (boot_addr_i),
    .mstatus_i    (mstatus_rdata),
    .mepc_i       (mepc_o),        // mepc goes out and back into the read mux
    .mcause_i     (mcause),
    .cnt_rdata_i  (cnt_rdata),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .rdata_o      (rdata_o),
    .wr_data_o    (wr_data),
    .wr_mstatus_o (wr_mstatus),
    .wr_mepc_o    (wr_mepc),
    .wr_mcause_o  (wr_mcause),
    .sel_pcer_o   (sel_pcer),
    .sel_pcmr_o   (sel_pcmr),
    .cnt_we_o     (cnt_we),
    .sel_all_o    (sel_all),
    .sel_index_o  (sel_cnt)
  );

  machine_csrs i_machine_csrs (
    .clk          (clk),
    .rst_n        (rst_n),
    .trap_i       (trap_i),
    .wr_data_i    (wr_data),
    .wr_mstatus_i (wr_mstatus),
    .wr_mepc_i    (wr_mepc),
    .wr_mcause_i  (wr_mcause),
    .mstatus_o    (mstatus_rdata),
    .mepc_o       (mepc_o),
    .mcause_o     (mcause),
    .irq_enable_o (irq_enable_o)
  );

  perf_counters i_perf_counters (
    .clk          (clk),
    .rst_n        (rst_n),
    .events_i     (events_i),
    .wr_data_i    (wr_data),
    .sel_pcer_i   (sel_pcer),
    .sel_pcmr_i   (sel_pcmr),
    .cnt_we_i     (cnt_we),
    .sel_all_i    (sel_all),
    .sel_index_i  (sel_cnt),
    .cnt_rdata_o  (cnt_rdata),
    .pcer_o       (pcer),
    .pcmr_o       (pcmr)
  );

endmodule

// ==== tests/cs_registers_model.svh ====
// reference model of the csr block: operation results, mstatus image and counter steps
`ifndef CS_REGISTERS_MODEL_SVH
`define CS_REGISTERS_MODEL_SVH

// new register value for one access operation
function automatic logic [31:0] op_result(input csr_pkg::csr_op_e op,
                                          input logic [31:0]      old,
                                          input logic [31:0]      wdata);
  case (op)
    csr_pkg::WRITE: return wdata;
    csr_pkg::SET:   return old | wdata;
    csr_pkg::CLEAR: return old & ~wdata;
    default:        return old;
  endcase
endfunction

// mstatus as read: mie, mpie and mpp fixed to machine mode
function automatic logic [31:0] mstatus_image(input logic mie, input logic mpie);
  return {19'b0, 2'b11, 3'b0, mpie, 3'b0, mie, 3'b0};
endfunction

// counters that see their event this cycle, before mask and global enable
function automatic logic [7:0] event_hits(input csr_pkg::perf_events_t ev);
  return {ev.branch_taken, ev.branch, ev.jump, ev.store, ev.load,
          ev.imiss & ~ev.pc_set,  // fetch miss unless a jump is under way
          ev.instr_valid,
          1'b1};                  // counter 0 counts cycles
endfunction

// counter value after one counted event
function automatic logic [31:0] count_step(input logic [31:0] val, input logic sat);
  return (sat && (&val)) ? val : val + 32'd1;  // hold at all-ones when saturating
endfunction

`endif

// ==== tests/cs_registers_tb.sv ====
// testbench for the machine-mode csr block with a cycle model and a compare process

`timescale 1ns/1ps

module cs_registers_tb;

  localparam int CLK_PERIOD  = 20;
  localparam int N_OPS       = 20;  // random accesses per target
  localparam int N_COUNT     = 40;  // cycles of random events
  localparam int TEST_CYCLES = 3 * N_OPS + N_COUNT + 90;

  `include "cs_registers_model.svh"

  logic                  clk;
  logic                  rst_n;
  csr_pkg::csr_req_t     csr_req;
  csr_pkg::trap_ctrl_t   trap;
  csr_pkg::perf_events_t events;
  logic [31:0]           boot_addr;
  logic [31:0]           rdata;
  logic                  irq_enable;
  logic [31:0]           mepc;

  // model state
  logic        mie_m    = 1'b0;
  logic        mpie_m   = 1'b0;
  logic [31:0] mepc_m   = '0;
  logic [31:0] mcause_m = '0;
  logic [7:0]  pcer_m   = '0;
  logic [1:0]  pcmr_m   = 2'b11;
  logic [31:0] cnt_m [8];
  logic [11:0] targets [3] = '{csr_pkg::MEPC, csr_pkg::MCAUSE, csr_pkg::PCER};

  csr_pkg::perf_events_t ev_cur;
  csr_pkg::trap_ctrl_t   trap_cur;
  logic        armed;
  logic        exp_irq;
  logic [31:0] exp_rd;
  logic [31:0] exp_mepc;
  logic [31:0] r;
  int          seed   = 51;
  int          checks = 0;
  int          errors = 0;

  cs_registers i_cs_registers (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req),
    .trap_i       (trap),
    .events_i     (events),
    .boot_addr_i  (boot_addr),
    .rdata_o      (rdata),
    .irq_enable_o (irq_enable),
    .mepc_o       (mepc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // expected read value of a register number
  function automatic logic [31:0] read_model(input logic [11:0] addr);
    case (addr)
      csr_pkg::MSTATUS: return mstatus_image(mie_m, mpie_m);
      csr_pkg::MISA:    return csr_pkg::MISA_VALUE;
      csr_pkg::MTVEC:   return boot_addr;
      csr_pkg::MEPC:    return mepc_m;
      csr_pkg::MCAUSE:  return mcause_m;
      csr_pkg::PCER:    return {24'b0, pcer_m};
      csr_pkg::PCMR:    return {30'b0, pcmr_m};
      default:          return (addr[11:5] == csr_pkg::PCCR_PAGE && addr[4:0] < 8) ?
                               cnt_m[addr[2:0]] : '0;  // all-select reads zero too
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // drives one access cycle, sets its expectations and advances the model
  ////////////////////////////////////////////////////////////

  task automatic step(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                      input logic [31:0] wdata);
    csr_pkg::csr_req_t req;
    logic [31:0]       rd;
    logic [31:0]       nv;
    logic [7:0]        hits;
    logic              mie_old;
    logic              mpie_old;
    @(posedge clk);
    req.access = 1'b1;
    req.addr   = addr;
    req.op     = op;
    req.wdata  = wdata;
    rd         = read_model(addr);
    nv         = op_result(op, rd, wdata);
    hits       = event_hits(ev_cur) & pcer_m & {8{pcmr_m[csr_pkg::PCMR_EN_BIT]}};
    mie_old    = mie_m;
    mpie_old   = mpie_m;
    csr_req  <= req;
    trap     <= trap_cur;
    events   <= ev_cur;
    armed    <= 1'b1;
    exp_rd   <= rd;
    exp_irq  <= mie_m;   // state left by the previous cycle
    exp_mepc <= mepc_m;
    if (op != csr_pkg::NONE) begin
      case (addr)
        csr_pkg::MSTATUS: begin
          mie_m  = nv[csr_pkg::MSTATUS_MIE_BIT];
          mpie_m = nv[csr_pkg::MSTATUS_MPIE_BIT];
        end
        csr_pkg::MEPC:     mepc_m   = nv;
        csr_pkg::MCAUSE:   mcause_m = nv & 32'h8000_001F;  // irq flag and code only
        csr_pkg::PCER:     pcer_m   = nv[7:0];
        csr_pkg::PCMR:     pcmr_m   = nv[1:0];
        csr_pkg::PCCR_ALL: foreach (cnt_m[c]) cnt_m[c] = nv;
        default: begin
          if (addr[11:5] == csr_pkg::PCCR_PAGE && addr[4:0] < 8) cnt_m[addr[2:0]] = nv;
        end
      endcase
    end
    // trap entry beats mret and both beat the software write
    if (trap_cur.save_cause) begin
      mepc_m   = trap_cur.save_if ? trap_cur.pc_if : trap_cur.pc_id;
      mcause_m = {trap_cur.cause.irq, 26'b0, trap_cur.cause.code};
      mpie_m   = mie_old;
      mie_m    = 1'b0;
    end else if (trap_cur.restore_mret) begin
      mie_m  = mpie_old;
      mpie_m = 1'b1;
    end
    foreach (cnt_m[c]) begin
      if (hits[c]) cnt_m[c] = count_step(cnt_m[c], pcmr_m[csr_pkg::PCMR_SAT_BIT]);
    end
  endtask

  // optionally stop counting, let the increment drain, read slots 0 to 9
  task automatic read_counters(input logic stop);
    if (stop) step(csr_pkg::PCMR, csr_pkg::WRITE, '0);
    repeat (2) step(csr_pkg::MISA, csr_pkg::NONE, '0);
    for (int c = 0; c < 10; c++) step(12'h780 + 12'(c), csr_pkg::NONE, '0);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (armed) begin
      check_value("irq_enable_o", {31'b0, irq_enable}, {31'b0, exp_irq});
      check_value("mepc_o", mepc, exp_mepc);
      check_value("rdata_o", rdata, exp_rd);
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    csr_req   = '0;
    trap      = '0;
    events    = '0;
    boot_addr = 32'h1c00_0080;
    ev_cur    = '0;
    trap_cur  = '0;
    armed     = 1'b0;
    foreach (cnt_m[c]) cnt_m[c] = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // reset values and constants
    step(csr_pkg::MISA, csr_pkg::NONE, '0);
    step(csr_pkg::MTVEC, csr_pkg::NONE, '0);
    step(csr_pkg::MSTATUS, csr_pkg::NONE, '0);
    step(csr_pkg::PCMR, csr_pkg::NONE, '0);
    step(csr_pkg::PCER, csr_pkg::NONE, '0);

    // random write, set and clear on mepc, mcause and pcer
    for (int i = 0; i < N_OPS; i++) begin
      foreach (targets[t]) begin
        r = $random(seed);
        step(targets[t], csr_pkg::csr_op_e'(r % 3 + 1), $random(seed));
      end
    end
    foreach (targets[t]) step(targets[t], csr_pkg::NONE, '0);

    // traps from fetch, from decode, and one racing an mepc write
    step(csr_pkg::MSTATUS, csr_pkg::SET, 32'h8);
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      trap_cur.save_cause = 1'b1;
      trap_cur.save_if    = (k != 1);
      trap_cur.save_id    = (k == 1);
      trap_cur.cause      = r[5:0];
      trap_cur.pc_if      = $random(seed);
      trap_cur.pc_id      = $random(seed);
      step(csr_pkg::MEPC, (k == 2) ? csr_pkg::WRITE : csr_pkg::NONE, $random(seed));
      trap_cur = '0;
      step(csr_pkg::MSTATUS, csr_pkg::NONE, '0);
      trap_cur.restore_mret = 1'b1;
      step(csr_pkg::MCAUSE, csr_pkg::NONE, '0);
      trap_cur = '0;
      step(csr_pkg::MEPC, csr_pkg::NONE, '0);
    end

    // random events under a random mask
    r = $random(seed);
    step(csr_pkg::PCER, csr_pkg::WRITE, {24'b0, r[7:0]});
    step(csr_pkg::PCCR_ALL, csr_pkg::WRITE, '0);
    for (int i = 0; i < N_COUNT; i++) begin
      r      = $random(seed);
      ev_cur = r[7:0];
      step(csr_pkg::MISA, csr_pkg::NONE, '0);
    end
    ev_cur = '0;
    read_counters(1'b1);

    // load all-ones everywhere, saturate, then wrap
    step(csr_pkg::PCMR, csr_pkg::WRITE, 32'd3);
    step(csr_pkg::PCER, csr_pkg::WRITE, 32'hFF);
    step(csr_pkg::PCCR_ALL, csr_pkg::WRITE, '1);
    ev_cur = 8'hDF;  // every event but pc_set
    repeat (4) step(csr_pkg::MISA, csr_pkg::NONE, '0);
    ev_cur = '0;
    read_counters(1'b0);
    step(csr_pkg::PCMR, csr_pkg::WRITE, 32'd1);
    ev_cur = 8'hDF;
    repeat (3) step(csr_pkg::MISA, csr_pkg::NONE, '0);
    ev_cur = '0;
    read_counters(1'b1);
    step(12'h79E, csr_pkg::NONE, '0);
    step(csr_pkg::PCCR_ALL, csr_pkg::NONE, '0);

    @(posedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // ends a hung run well past the longest sequence
  initial begin
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES + 100);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+tests
verilog/csr_pkg.sv
verilog/csr_access.sv
verilog/machine_csrs.sv
verilog/perf_counters.sv
verilog/cs_registers.sv
tests/cs_registers_tb.sv
